// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - include_dirs:
      - include
    files:
      - source/csr_pkg.sv
      - source/csr_if.sv
      - source/csr_decode.sv
      - source/csr_alu.sv
      - source/csr_regfile.sv
      - source/csr_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_csr_unit.sv

// ==== include/csr_defs.svh ====
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

`define XLEN 32

// machine level
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MEDELEG   12'h302
`define CSR_MIDELEG   12'h303
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344

// supervisor level
`define CSR_SSTATUS   12'h100
`define CSR_SIE       12'h104
`define CSR_STVEC     12'h105
`define CSR_SSCRATCH  12'h140
`define CSR_SEPC      12'h141
`define CSR_SCAUSE    12'h142
`define CSR_STVAL     12'h143
`define CSR_SIP       12'h144

// machine info, read only
`define CSR_MVENDORID 12'hF11
`define CSR_MARCHID   12'hF12
`define CSR_MIMPID    12'hF13
`define CSR_MHARTID   12'hF14

`define OPC_SYSTEM    7'b1110011

`define F3_PRIV       3'b000	// ecall, ebreak, xret
`define F3_CSRRW      3'b001
`define F3_CSRRS      3'b010
`define F3_CSRRC      3'b011
`define F3_CSRRWI     3'b101
`define F3_CSRRSI     3'b110
`define F3_CSRRCI     3'b111

`define INSTR_MRET    32'h30200073
`define INSTR_SRET    32'h10200073

`define EXC_INSTR_MISALIGNED 31'd0	// only cause that fills xtval

`endif

// ==== list.f ====
+incdir+include
source/csr_pkg.sv
source/csr_if.sv
source/csr_decode.sv
source/csr_alu.sv
source/csr_regfile.sv
source/csr_unit.sv
testbench/tb_csr_unit.sv

// ==== source/csr_alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_defs.svh"

module csr_alu import csr_pkg::*;
(
	csr_if.sink       csr_req,
	input  word_t     rd_data,	// old value of the addressed csr
	output csr_addr_t wb_addr,
	output word_t     wb_data,
	output logic      wb_en
);

	logic [`XLEN-1:0] set_val;
	logic [`XLEN-1:0] clr_val;

	assign set_val = rd_data | csr_req.operand;
	assign clr_val = rd_data & ~csr_req.operand;

	always_comb
	begin
		wb_data = rd_data;
		wb_en   = 1'b0;
		case (csr_req.op)
			RW:
			begin
				wb_data = csr_req.operand;
				wb_en   = 1'b1;	// swap writes even with x0
			end
			RS:
			begin
				wb_data = set_val;
				wb_en   = !csr_req.src_zero;
			end
			RC:
			begin
				wb_data = clr_val;
				wb_en   = !csr_req.src_zero;
			end
			default:
			begin
				wb_en = 1'b0;
			end
		endcase
	end

	assign wb_addr = csr_req.addr;

endmodule

`default_nettype wire

// ==== source/csr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_defs.svh"

module csr_decode import csr_pkg::*;
(
	input  logic  instr_valid,
	input  word_t instr,
	input  word_t rs1_data,
	input  mode_t current_mode,
	csr_if.source csr_req,
	output logic  mret,
	output logic  sret,
	output logic  illegal
);

	logic [2:0] funct3;
	logic [4:0] rs1_field;
	csr_addr_t  addr;
	csr_op_t    op_dec;
	logic       is_system, is_csr, is_mret, is_sret;
	logic       write_try, addr_ok, priv_ok, csr_bad, ret_bad;

	assign funct3    = instr[14:12];
	assign rs1_field = instr[19:15];
	assign addr      = instr[31:20];

	assign is_system = instr_valid && (instr[6:0] == `OPC_SYSTEM);
	assign is_mret   = is_system && (instr == `INSTR_MRET);
	assign is_sret   = is_system && (instr == `INSTR_SRET);

	always_comb
	begin
		case (funct3[1:0])	// imm forms share the low bits
			2'b01:   op_dec = RW;
			2'b10:   op_dec = RS;
			2'b11:   op_dec = RC;
			default: op_dec = NONE;	// priv group and reserved 100
		endcase
	end

	assign is_csr = is_system && (op_dec != NONE);

	always_comb
	begin
		case (addr)
			`CSR_MSTATUS, `CSR_MISA, `CSR_MEDELEG, `CSR_MIDELEG, `CSR_MIE,
			`CSR_MTVEC, `CSR_MSCRATCH, `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL,
			`CSR_MIP, `CSR_SSTATUS, `CSR_SIE, `CSR_STVEC, `CSR_SSCRATCH,
			`CSR_SEPC, `CSR_SCAUSE, `CSR_STVAL, `CSR_SIP, `CSR_MVENDORID,
			`CSR_MARCHID, `CSR_MIMPID, `CSR_MHARTID:
				addr_ok = 1'b1;
			default:
				addr_ok = 1'b0;
		endcase
	end

	// rs/rc with a zero source only read
	assign write_try = (op_dec == RW) || (rs1_field != 5'd0);
	assign priv_ok   = addr[9:8] <= current_mode;
	// misa is fixed here, so a write traps as well
	assign csr_bad   = !addr_ok || !priv_ok ||
	                   (write_try && ((addr[11:10] == 2'b11) || (addr == `CSR_MISA)));
	assign ret_bad   = (is_mret && current_mode != M) || (is_sret && current_mode == U);

	assign illegal = (is_csr && csr_bad) || ret_bad;
	assign mret    = is_mret && !ret_bad;
	assign sret    = is_sret && !ret_bad;

	assign csr_req.op       = (is_csr && !csr_bad) ? op_dec : NONE;
	assign csr_req.addr     = addr;
	assign csr_req.operand  = funct3[2] ? {27'd0, rs1_field} : rs1_data;
	assign csr_req.src_zero = rs1_field == 5'd0;

endmodule

`default_nettype wire

// ==== source/csr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// decoded csr access, valid in the cycle of instr_valid
interface csr_if import csr_pkg::*;
();

	csr_op_t   op;		// NONE when nothing to do
	csr_addr_t addr;
	word_t     operand;	// rs1 value or zero-extended uimm
	logic      src_zero;	// rs1 field / uimm is zero

	modport source
	(
		output op,
		output addr,
		output operand,
		output src_zero
	);

	modport sink
	(
		input op,
		input addr,
		input operand,
		input src_zero
	);

endinterface

`default_nettype wire

// ==== source/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

	// data word, also used for rs1 data and pc
	typedef logic [31:0] word_t;

	typedef logic [11:0] csr_addr_t;

	// bit 31 set for interrupts, low bits hold the code
	typedef logic [31:0] cause_t;

	// privilege levels, encoded as in the spec
	typedef enum logic [1:0]
	{
		U = 2'b00,
		S = 2'b01,
		M = 2'b11
	} mode_t;

	// read-modify-write flavour of a csr instruction
	typedef enum logic [1:0]
	{
		NONE = 2'b00,
		RW   = 2'b01,	// swap
		RS   = 2'b10,	// set bits
		RC   = 2'b11	// clear bits
	} csr_op_t;

endpackage

`default_nettype wire

// ==== source/csr_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_defs.svh"

module csr_regfile import csr_pkg::*;
(
	input  logic      clk,
	input  logic      nrst,
	input  csr_addr_t rd_addr,
	input  csr_addr_t wb_addr,
	input  word_t     wb_data,
	input  logic      wb_en,
	input  logic      mret,
	input  logic      sret,
	input  logic      exception_pending,
	input  cause_t    cause,
	input  word_t     pc_exc,	// pc of the trapping instruction
	input  logic      m_interrupt,
	input  logic      s_interrupt,
	output word_t     rd_data,
	output mode_t     current_mode,
	output word_t     epc,	// next pc on trap or return
	output logic      m_eie,
	output logic      m_tie,
	output logic      s_eie,
	output logic      s_tie
);

	// mstatus fields
	logic  status_sie, status_mie, status_spie, status_mpie, status_spp, status_sum;
	mode_t status_mpp;

	// mie bits
	logic meie, seie, mtie, stie;

	logic [`XLEN-1:2] mtvec, stvec, mepc, sepc;	// low bits read as zero
	word_t  mscratch, sscratch, mtval, stval, medeleg, mideleg;
	cause_t mcause, scause;

	word_t mstatus_v, sstatus_v, mie_v, sie_v, mip_v, sip_v;
	logic  to_s;
	word_t tval_val;

	assign mstatus_v = {13'b0, status_sum, 5'b0, status_mpp, 2'b0, status_spp, status_mpie,
	                    1'b0, status_spie, 1'b0, status_mie, 1'b0, status_sie, 1'b0};
	assign sstatus_v = {13'b0, status_sum, 9'b0, status_spp, 2'b0, status_spie, 3'b0,
	                    status_sie, 1'b0};
	assign mie_v = {20'b0, meie, 1'b0, seie, 1'b0, mtie, 1'b0, stie, 5'b0};
	assign sie_v = {22'b0, seie, 3'b0, stie, 5'b0};
	assign mip_v = {20'b0, m_interrupt, 1'b0, s_interrupt, 9'b0};	// external pending only
	assign sip_v = {22'b0, s_interrupt, 9'b0};

	always_comb
	begin
		case (rd_addr)
			`CSR_MSTATUS:  rd_data = mstatus_v;
			`CSR_MISA:     rd_data = {2'b01, 4'b0, 26'h0040100};	// rv32 with S and I
			`CSR_MEDELEG:  rd_data = medeleg;
			`CSR_MIDELEG:  rd_data = mideleg;
			`CSR_MIE:      rd_data = mie_v;
			`CSR_MTVEC:    rd_data = {mtvec, 2'b00};	// direct mode only
			`CSR_MSCRATCH: rd_data = mscratch;
			`CSR_MEPC:     rd_data = {mepc, 2'b00};
			`CSR_MCAUSE:   rd_data = mcause;
			`CSR_MTVAL:    rd_data = mtval;
			`CSR_MIP:      rd_data = mip_v;
			`CSR_SSTATUS:  rd_data = sstatus_v;
			`CSR_SIE:      rd_data = sie_v;
			`CSR_STVEC:    rd_data = {stvec, 2'b00};
			`CSR_SSCRATCH: rd_data = sscratch;
			`CSR_SEPC:     rd_data = {sepc, 2'b00};
			`CSR_SCAUSE:   rd_data = scause;
			`CSR_STVAL:    rd_data = stval;
			`CSR_SIP:      rd_data = sip_v;
			default:       rd_data = '0;	// id registers and unknown
		endcase
	end

	// delegation never lowers a trap taken in M mode
	assign to_s = (cause[31] ? mideleg[cause[4:0]] : medeleg[cause[4:0]]) &&
	              (current_mode != M);

	assign tval_val = (!cause[31] && cause[30:0] == `EXC_INSTR_MISALIGNED) ? pc_exc : '0;

	always_comb
	begin
		if (mret)
			epc = {mepc, 2'b00};
		else if (sret)
			epc = {sepc, 2'b00};
		else if (exception_pending && to_s)
			epc = {stvec, 2'b00};
		else
			epc = {mtvec, 2'b00};
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			current_mode <= M;
			status_sie   <= 1'b0;
			status_mie   <= 1'b0;
			status_spie  <= 1'b0;
			status_mpie  <= 1'b0;
			status_spp   <= 1'b0;
			status_mpp   <= M;
			status_sum   <= 1'b0;
			meie         <= 1'b0;
			seie         <= 1'b0;
			mtie         <= 1'b0;
			stie         <= 1'b0;
			mtvec        <= '0;
			stvec        <= '0;
			mepc         <= '0;
			sepc         <= '0;
			mscratch     <= '0;
			sscratch     <= '0;
			mtval        <= '0;
			stval        <= '0;
			medeleg      <= '0;
			mideleg      <= '0;
			mcause       <= '0;
			scause       <= '0;
		end
		else if (exception_pending)	// wins over writes and returns
		begin
			if (to_s)
			begin
				sepc         <= pc_exc[`XLEN-1:2];
				scause       <= cause;
				stval        <= tval_val;
				status_spie  <= status_sie;
				status_sie   <= 1'b0;
				status_spp   <= current_mode[0];	// U or S only
				current_mode <= S;
			end
			else
			begin
				mepc         <= pc_exc[`XLEN-1:2];
				mcause       <= cause;
				mtval        <= tval_val;
				status_mpie  <= status_mie;
				status_mie   <= 1'b0;
				status_mpp   <= current_mode;
				current_mode <= M;
			end
		end
		else if (mret)
		begin
			status_mie   <= status_mpie;
			status_mpie  <= 1'b1;
			status_mpp   <= U;
			current_mode <= status_mpp;
		end
		else if (sret)
		begin
			status_sie   <= status_spie;
			status_spie  <= 1'b1;
			status_spp   <= 1'b0;
			current_mode <= status_spp ? S : U;
		end
		else if (wb_en)
		begin
			case (wb_addr)
				`CSR_MSTATUS:
				begin
					status_sie  <= wb_data[1];
					status_mie  <= wb_data[3];
					status_spie <= wb_data[5];
					status_mpie <= wb_data[7];
					status_spp  <= wb_data[8];
					// reserved encoding 10 falls back to U
					status_mpp  <= (wb_data[12:11] == 2'b10) ? U : mode_t'(wb_data[12:11]);
					status_sum  <= wb_data[18];
				end
				`CSR_SSTATUS:
				begin
					status_sie  <= wb_data[1];
					status_spie <= wb_data[5];
					status_spp  <= wb_data[8];
					status_sum  <= wb_data[18];
				end
				`CSR_MIE:
				begin
					stie <= wb_data[5];
					mtie <= wb_data[7];
					seie <= wb_data[9];
					meie <= wb_data[11];
				end
				`CSR_SIE:
				begin
					stie <= wb_data[5];
					seie <= wb_data[9];
				end
				`CSR_MEDELEG:  medeleg  <= wb_data;
				`CSR_MIDELEG:  mideleg  <= wb_data;
				`CSR_MTVEC:    mtvec    <= wb_data[`XLEN-1:2];
				`CSR_STVEC:    stvec    <= wb_data[`XLEN-1:2];
				`CSR_MSCRATCH: mscratch <= wb_data;
				`CSR_SSCRATCH: sscratch <= wb_data;
				`CSR_MEPC:     mepc     <= wb_data[`XLEN-1:2];
				`CSR_SEPC:     sepc     <= wb_data[`XLEN-1:2];
				`CSR_MCAUSE:   mcause   <= wb_data;
				`CSR_SCAUSE:   scause   <= wb_data;
				`CSR_MTVAL:    mtval    <= wb_data;
				`CSR_STVAL:    stval    <= wb_data;
				default:       ;	// mip, sip and misa hold no state
			endcase
		end
	end

	assign m_eie = meie && status_mie;
	assign m_tie = mtie && status_mie;
	assign s_eie = seie && status_sie;
	assign s_tie = stie && status_sie;

endmodule

`default_nettype wire

// ==== source/csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit import csr_pkg::*;
(
	input  logic   clk,
	input  logic   nrst,
	input  logic   instr_valid,
	input  word_t  instr,
	input  word_t  rs1_data,
	input  logic   exception_pending,
	input  cause_t cause,
	input  word_t  pc_exc,
	input  logic   m_interrupt,
	input  logic   s_interrupt,
	output word_t  rd_data,
	output logic   illegal,
	output mode_t  current_mode,
	output word_t  epc,
	output logic   m_eie,
	output logic   m_tie,
	output logic   s_eie,
	output logic   s_tie
);

	csr_addr_t wb_addr;
	word_t     wb_data;
	logic      wb_en;
	logic      mret;
	logic      sret;

	csr_if csr_req();

	csr_decode i_decode
	(
		.instr_valid  (instr_valid),
		.instr        (instr),
		.rs1_data     (rs1_data),
		.current_mode (current_mode),
		.csr_req      (csr_req.source),
		.mret         (mret),
		.sret         (sret),
		.illegal      (illegal)
	);

	csr_alu i_alu
	(
		.csr_req (csr_req.sink),
		.rd_data (rd_data),
		.wb_addr (wb_addr),
		.wb_data (wb_data),
		.wb_en   (wb_en)
	);

	csr_regfile i_regfile
	(
		.clk               (clk),
		.nrst              (nrst),
		.rd_addr           (csr_req.addr),	// read port follows the decoded address
		.wb_addr           (wb_addr),
		.wb_data           (wb_data),
		.wb_en             (wb_en),
		.mret              (mret),
		.sret              (sret),
		.exception_pending (exception_pending),
		.cause             (cause),
		.pc_exc            (pc_exc),
		.m_interrupt       (m_interrupt),
		.s_interrupt       (s_interrupt),
		.rd_data           (rd_data),
		.current_mode      (current_mode),
		.epc               (epc),
		.m_eie             (m_eie),
		.m_tie             (m_tie),
		.s_eie             (s_eie),
		.s_tie             (s_tie)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_defs.svh"

module tb_csr_unit import csr_pkg::*;
();

	localparam int clk_period = 4;
	localparam int op_count   = 45;	// csr instructions plus mret and sret at 2 cycles each
	localparam int exc_count  = 4;	// exception strobes at 3 cycles each
	localparam int reset_len  = 4;
	localparam int margin_ns  = 200;
	localparam int run_ns     = (op_count * 2 + exc_count * 3 + reset_len) * clk_period;

	logic   clk;
	logic   nrst;
	logic   instr_valid;
	word_t  instr;
	word_t  rs1_data;
	logic   exception_pending;
	cause_t cause;
	word_t  pc_exc;
	logic   m_interrupt;
	logic   s_interrupt;
	word_t  rd_data;
	logic   illegal;
	mode_t  current_mode;
	word_t  epc;
	logic   m_eie, m_tie, s_eie, s_tie;

	int          errors;
	logic [31:0] lfsr;
	word_t       got_rd, got_epc;	// sampled at the falling edge
	logic        got_ill;

	// reference model of the mode and mstatus fields
	mode_t       exp_mode;
	logic        ref_sie, ref_mie, ref_spie, ref_mpie, ref_spp;
	logic [1:0]  ref_mpp;
	word_t       ref_mscratch;

	csr_unit i_dut
	(
		.clk               (clk),
		.nrst              (nrst),
		.instr_valid       (instr_valid),
		.instr             (instr),
		.rs1_data          (rs1_data),
		.exception_pending (exception_pending),
		.cause             (cause),
		.pc_exc            (pc_exc),
		.m_interrupt       (m_interrupt),
		.s_interrupt       (s_interrupt),
		.rd_data           (rd_data),
		.illegal           (illegal),
		.current_mode      (current_mode),
		.epc               (epc),
		.m_eie             (m_eie),
		.m_tie             (m_tie),
		.s_eie             (s_eie),
		.s_tie             (s_tie)
	);

	always #(clk_period / 2) clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1 stepped once per bit
	function automatic word_t lfsr_word();
		word_t w;
		logic  fb;
		w = '0;
		for (int i = 0; i < 32; i++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			w    = {w[30:0], fb};
		end
		return w;
	endfunction

	function automatic word_t csr_instr(input logic [2:0] f3, input csr_addr_t addr,
	                                    input logic [4:0] src);
		return {addr, src, f3, 5'd5, `OPC_SYSTEM};	// rd = x5
	endfunction

	function automatic word_t expected_mstatus();
		return {19'b0, ref_mpp, 2'b0, ref_spp, ref_mpie, 1'b0, ref_spie, 1'b0, ref_mie,
		        1'b0, ref_sie, 1'b0};
	endfunction

	function automatic word_t expected_sstatus();
		return {23'b0, ref_spp, 2'b0, ref_spie, 3'b0, ref_sie, 1'b0};
	endfunction

	task automatic compare_word(input string name, input word_t exp, input word_t got);
		if (got !== exp)
		begin
			$display("FAIL %s: expected %h, actual %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic compare_mode(input string name);
		compare_word(name, {30'b0, exp_mode}, {30'b0, current_mode});
	endtask

	task automatic model_status_write(input word_t w);
		ref_sie  = w[1];
		ref_mie  = w[3];
		ref_spie = w[5];
		ref_mpie = w[7];
		ref_spp  = w[8];
		ref_mpp  = w[12:11];
	endtask

	task automatic model_trap(input logic to_s);
		if (to_s)
		begin
			ref_spie = ref_sie;
			ref_sie  = 1'b0;
			ref_spp  = (exp_mode == S);
			exp_mode = S;
		end
		else
		begin
			ref_mpie = ref_mie;
			ref_mie  = 1'b0;
			ref_mpp  = exp_mode;
			exp_mode = M;
		end
	endtask

	task automatic model_mret();
		ref_mie  = ref_mpie;
		ref_mpie = 1'b1;
		exp_mode = mode_t'(ref_mpp);
		ref_mpp  = U;
	endtask

	task automatic model_sret();
		ref_sie  = ref_spie;
		ref_spie = 1'b1;
		exp_mode = ref_spp ? S : U;
		ref_spp  = 1'b0;
	endtask

	// one instruction for one cycle with outputs taken mid-cycle
	task automatic run_instr(input word_t w, input word_t src_val);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= w;
		rs1_data    <= src_val;
		@(negedge clk);
		got_rd  = rd_data;
		got_ill = illegal;
		got_epc = epc;
		@(posedge clk);
		instr_valid <= 1'b0;
		instr       <= 32'h0000_0013;	// nop
		rs1_data    <= '0;
	endtask

	task automatic csr_op(input logic [2:0] f3, input csr_addr_t addr, input logic [4:0] src,
	                      input word_t val);
		run_instr(csr_instr(f3, addr, src), val);
	endtask

	task automatic read_csr(input csr_addr_t addr);
		csr_op(`F3_CSRRS, addr, 5'd0, '0);
	endtask

	task automatic raise_exception(input cause_t c, input word_t pc);
		@(posedge clk);
		exception_pending <= 1'b1;
		cause             <= c;
		pc_exc            <= pc;
		@(negedge clk);
		got_epc = epc;
		@(posedge clk);
		exception_pending <= 1'b0;
		cause             <= '0;
		pc_exc            <= '0;
		@(negedge clk);	// new mode visible here
	endtask

	task automatic test_csrrw();
		word_t v1, v2, v3;
		v1 = lfsr_word();
		v2 = lfsr_word();
		v3 = lfsr_word();
		csr_op(`F3_CSRRW, `CSR_MSCRATCH, 5'd7, v1);
		compare_word("csrrw mscratch old", 32'h0, got_rd);
		csr_op(`F3_CSRRW, `CSR_MSCRATCH, 5'd7, v2);
		compare_word("csrrw mscratch readback", v1, got_rd);
		ref_mscratch = v2;
		csr_op(`F3_CSRRW, `CSR_STVEC, 5'd7, v3);
		compare_word("csrrw stvec old", 32'h0, got_rd);
		read_csr(`CSR_STVEC);
		compare_word("csrrw stvec readback", v3 & ~32'h3, got_rd);
	endtask

	task automatic test_set_clear();
		word_t mask;
		mask = lfsr_word();
		csr_op(`F3_CSRRS, `CSR_MSCRATCH, 5'd9, mask);
		compare_word("csrrs old", ref_mscratch, got_rd);
		ref_mscratch = ref_mscratch | mask;
		mask = lfsr_word();
		csr_op(`F3_CSRRC, `CSR_MSCRATCH, 5'd9, mask);
		compare_word("csrrc old", ref_mscratch, got_rd);
		ref_mscratch = ref_mscratch & ~mask;
		read_csr(`CSR_MSCRATCH);
		compare_word("csrrc result", ref_mscratch, got_rd);
		// rs1 data ignored for an x0 source
		csr_op(`F3_CSRRS, `CSR_MSCRATCH, 5'd0, lfsr_word());
		read_csr(`CSR_MSCRATCH);
		compare_word("csrrs x0 unchanged", ref_mscratch, got_rd);
		csr_op(`F3_CSRRCI, `CSR_MSCRATCH, 5'h1f, '0);
		compare_word("csrrci illegal", 32'h0, {31'b0, got_ill});
		ref_mscratch = ref_mscratch & ~32'h1f;
		read_csr(`CSR_MSCRATCH);
		compare_word("csrrci result", ref_mscratch, got_rd);
	endtask

	task automatic test_illegal();
		word_t v;
		csr_op(`F3_CSRRW, `CSR_MISA, 5'd3, lfsr_word());
		compare_word("misa write illegal", 32'h1, {31'b0, got_ill});
		read_csr(`CSR_MISA);
		compare_word("misa unchanged", (32'h1 << 30) | (32'h1 << 18) | (32'h1 << 8), got_rd);
		csr_op(`F3_CSRRW, 12'h7C0, 5'd1, lfsr_word());
		compare_word("unimplemented illegal", 32'h1, {31'b0, got_ill});
		// MPP = S so the mret drops to S
		csr_op(`F3_CSRRW, `CSR_MSTATUS, 5'd1, 32'h0000_0800);
		model_status_write(32'h0000_0800);
		run_instr(`INSTR_MRET, '0);
		model_mret();
		@(negedge clk);
		compare_mode("illegal enter s mode");
		read_csr(`CSR_MSCRATCH);
		compare_word("s mode mscratch illegal", 32'h1, {31'b0, got_ill});
		v = lfsr_word();
		csr_op(`F3_CSRRW, `CSR_SSCRATCH, 5'd4, v);
		compare_word("s mode sscratch legal", 32'h0, {31'b0, got_ill});
		read_csr(`CSR_SSCRATCH);
		compare_word("s mode sscratch readback", v, got_rd);
		raise_exception(32'd3, lfsr_word());	// nothing delegated yet
		model_trap(1'b0);
		compare_mode("illegal back to m mode");
	endtask

	task automatic test_trap_m();
		word_t tv, pc;
		tv = lfsr_word();
		pc = lfsr_word();
		csr_op(`F3_CSRRW, `CSR_MTVEC, 5'd2, tv);
		csr_op(`F3_CSRRW, `CSR_MSTATUS, 5'd1, 32'h0000_0008);
		model_status_write(32'h0000_0008);
		csr_op(`F3_CSRRW, `CSR_MIE, 5'd1, 32'h0000_0800);
		@(negedge clk);
		compare_word("trap m_eie before", 32'h1, {31'b0, m_eie});
		raise_exception(32'd2, pc);
		model_trap(1'b0);
		compare_word("trap epc is mtvec", tv & ~32'h3, got_epc);
		compare_mode("trap mode");
		compare_word("trap m_eie after", 32'h0, {31'b0, m_eie});
		read_csr(`CSR_MEPC);
		compare_word("trap mepc", pc & ~32'h3, got_rd);
		read_csr(`CSR_MCAUSE);
		compare_word("trap mcause", 32'd2, got_rd);
		read_csr(`CSR_MTVAL);
		compare_word("trap mtval", 32'h0, got_rd);
		read_csr(`CSR_MSTATUS);
		compare_word("trap mstatus", expected_mstatus(), got_rd);
	endtask

	task automatic test_delegation();
		word_t sv, mv, pc;
		sv = lfsr_word();
		mv = lfsr_word();
		pc = lfsr_word();
		csr_op(`F3_CSRRW, `CSR_MEDELEG, 5'd1, 32'h0000_0001);	// misaligned fetch to S
		csr_op(`F3_CSRRW, `CSR_STVEC, 5'd2, sv);
		csr_op(`F3_CSRRW, `CSR_MEPC, 5'd2, mv);
		csr_op(`F3_CSRRW, `CSR_SCAUSE, 5'd2, lfsr_word());	// stale value for the trap to replace
		csr_op(`F3_CSRRW, `CSR_MSTATUS, 5'd1, 32'h0000_0802);
		model_status_write(32'h0000_0802);
		run_instr(`INSTR_MRET, '0);
		compare_word("deleg mret epc", mv & ~32'h3, got_epc);
		model_mret();
		@(negedge clk);
		compare_mode("deleg mode after mret");
		raise_exception(32'd0, pc);
		model_trap(1'b1);
		compare_word("deleg epc is stvec", sv & ~32'h3, got_epc);
		compare_mode("deleg trap mode");
		read_csr(`CSR_SEPC);
		compare_word("deleg sepc", pc & ~32'h3, got_rd);
		read_csr(`CSR_SCAUSE);
		compare_word("deleg scause", 32'd0, got_rd);
		read_csr(`CSR_STVAL);
		compare_word("deleg stval", pc, got_rd);
		read_csr(`CSR_SSTATUS);
		compare_word("deleg sstatus", expected_sstatus(), got_rd);
		run_instr(`INSTR_SRET, '0);
		compare_word("deleg sret epc", pc & ~32'h3, got_epc);
		model_sret();
		@(negedge clk);
		compare_mode("deleg sret to spp");
		run_instr(`INSTR_SRET, '0);	// SPP now U
		model_sret();
		@(negedge clk);
		compare_mode("deleg sret to u");
		raise_exception(32'd2, lfsr_word());
		model_trap(1'b0);
		compare_mode("deleg undelegated cause");
	endtask

	task automatic test_mret_enables();
		word_t mv, ev;
		mv = lfsr_word();
		ev = lfsr_word();
		csr_op(`F3_CSRRW, `CSR_MEPC, 5'd3, mv);
		csr_op(`F3_CSRRW, `CSR_MSTATUS, 5'd1, 32'h0000_1882);	// MPP = M with MPIE and SIE set
		model_status_write(32'h0000_1882);
		run_instr(`INSTR_MRET, '0);
		compare_word("mret epc", mv & ~32'h3, got_epc);
		model_mret();
		@(negedge clk);
		compare_mode("mret mode");
		read_csr(`CSR_MSTATUS);
		compare_word("mret mstatus", expected_mstatus(), got_rd);
		csr_op(`F3_CSRRW, `CSR_MIE, 5'd5, ev);
		@(negedge clk);
		compare_word("enables m_eie", {31'b0, ev[11] & ref_mie}, {31'b0, m_eie});
		compare_word("enables m_tie", {31'b0, ev[7] & ref_mie}, {31'b0, m_tie});
		compare_word("enables s_eie", {31'b0, ev[9] & ref_sie}, {31'b0, s_eie});
		compare_word("enables s_tie", {31'b0, ev[5] & ref_sie}, {31'b0, s_tie});
		csr_op(`F3_CSRRCI, `CSR_MSTATUS, 5'h8, '0);
		ref_mie = 1'b0;
		@(negedge clk);
		compare_word("enables mie cleared", 32'h0, {30'b0, m_eie, m_tie});
		csr_op(`F3_CSRRSI, `CSR_MSTATUS, 5'h8, '0);
		ref_mie = 1'b1;
		@(negedge clk);
		compare_word("enables mie set", {30'b0, ev[11], ev[7]}, {30'b0, m_eie, m_tie});
	endtask

	initial
	begin
		#(run_ns + margin_ns);
		$display("watchdog expired before the tests finished");
		$display("Some tests failed");
		$finish;
	end

	initial
	begin
		clk               = 1'b0;
		nrst              = 1'b0;
		instr_valid       = 1'b0;
		instr             = '0;
		rs1_data          = '0;
		exception_pending = 1'b0;
		cause             = '0;
		pc_exc            = '0;
		m_interrupt       = 1'b0;
		s_interrupt       = 1'b0;
		errors            = 0;
		lfsr              = 32'h5018;
		exp_mode          = M;
		ref_mpp           = M;
		{ref_sie, ref_mie, ref_spie, ref_mpie, ref_spp} = '0;
		ref_mscratch      = '0;
		repeat (reset_len) @(posedge clk);
		nrst <= 1'b1;

		test_csrrw();
		test_set_clear();
		test_illegal();
		test_trap_m();
		test_delegation();
		test_mret_enables();

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire
